//--- tb.f
+incdir+.
llc_consts_pkg.sv
llc_types_pkg.sv
llc_regs.sv
llc_ctrl.sv
llc_tag_array.sv
llc_top.sv
tb_llc.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_llc
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing -Wall
FAIL_MSG  := >>> FAIL
PASS_MSG  := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_llc_model.svh
`ifndef TB_LLC_MODEL_SVH
`define TB_LLC_MODEL_SVH

// expected tag state, one entry per set and way.
llc_types_pkg::llc_tag_t m_tag   [llc_consts_pkg::LLC_SETS][llc_consts_pkg::LLC_WAYS];
logic                    m_valid [llc_consts_pkg::LLC_SETS][llc_consts_pkg::LLC_WAYS];
int                      m_ptr   [llc_consts_pkg::LLC_SETS];

function automatic void invalidate_all();
    for (int s = 0; s < llc_consts_pkg::LLC_SETS; s++) begin
        m_ptr[s] = 0;
        for (int w = 0; w < llc_consts_pkg::LLC_WAYS; w++)
            m_valid[s][w] = 1'b0;
    end
endfunction

// looks up one line, allocates it on a miss and returns the expected response.
function automatic llc_types_pkg::llc_rsp_t lookup_line(input llc_types_pkg::line_addr_t addr,
                                                        input logic last);
    llc_types_pkg::llc_rsp_t            r;
    llc_types_pkg::line_breakdown_llc_t b;
    int                                 s;
    int                                 victim;
    r      = '0;
    b      = addr;
    s      = int'(b.set);
    r.addr = addr;
    r.last = last;
    for (int w = 0; w < llc_consts_pkg::LLC_WAYS; w++) begin
        if (m_valid[s][w] && m_tag[s][w] == b.tag)
            r.hit = 1'b1;
    end
    if (!r.hit) begin
        victim            = m_ptr[s];
        r.evict_valid     = m_valid[s][victim];
        r.evict_addr      = {m_tag[s][victim], b.set};
        m_tag[s][victim]   = b.tag;
        m_valid[s][victim] = 1'b1;
        m_ptr[s]          = (victim + 1) % llc_consts_pkg::LLC_WAYS;
    end
    return r;
endfunction

`endif

//--- tb_llc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_llc;

    localparam int          PERIOD     = 40;
    localparam int          RST_CYCLES = 16;
    localparam int unsigned SEED       = 32'h5a3ae244;
    localparam int          N_READS    = 300;
    localparam int          N_DMA      = 20;
    localparam int          N_HELD     = 30;
    localparam int          RSP_WAIT   = 80;

    // rough length of all tests in cycles.
    localparam int RUN_CYCLES = RST_CYCLES + 20 + N_READS * 10 + 200 + N_DMA * 60 + 200
                                + N_HELD * 120;

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    llc_types_pkg::llc_req_t req;
    logic                    ready;
    logic                    busy;
    logic                    rsp_valid;
    llc_types_pkg::llc_rsp_t rsp;

    int                      cycle_cnt;
    int                      sent_cycle;
    int                      errors;
    int                      test_errors;
    int                      rsp_count;
    llc_types_pkg::llc_rsp_t last_rsp;
    llc_types_pkg::llc_rsp_t exp_q[$];

    `include "tb_llc_model.svh"

    llc_top llc_top_i (.*);

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    task automatic report_value(input string name, input int exp, input int got);
        $display("ERR %s expected %0h got %0h at %0t ns", name, exp, got, $time);
        errors++;
    endtask

    task automatic report_fault(input string what);
        $display("error: %s at %0t ns", what, $time);
        errors++;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < RSP_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (busy)
            report_fault("controller stayed busy too long");
    endtask

    task automatic send_req(input llc_types_pkg::llc_req_t r);
        int n;
        n = 0;
        while (!ready && n < RSP_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!ready) begin
            report_fault("ready stayed low, request dropped");
            return;
        end
        req_valid  = 1'b1;
        req        = r;
        sent_cycle = cycle_cnt;
        @(negedge clk);
        req_valid = 1'b0;
        req       = '0;
    endtask

    // waits for the next response, compares it and returns its latency in cycles.
    task automatic expect_rsp(input llc_types_pkg::llc_rsp_t exp, output int latency);
        int n;
        n       = 0;
        latency = -1;
        while (!rsp_valid && n < RSP_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!rsp_valid) begin
            report_fault("no response arrived");
            return;
        end
        latency  = cycle_cnt - sent_cycle;
        last_rsp = rsp;
        rsp_count++;
        if (rsp.flush_done != exp.flush_done)
            report_value("rsp.flush_done", int'(exp.flush_done), int'(rsp.flush_done));
        if (rsp.hit != exp.hit)
            report_value("rsp.hit", int'(exp.hit), int'(rsp.hit));
        if (rsp.evict_valid != exp.evict_valid)
            report_value("rsp.evict_valid", int'(exp.evict_valid), int'(rsp.evict_valid));
        if (!exp.flush_done && rsp.addr != exp.addr)
            report_value("rsp.addr", int'(exp.addr), int'(rsp.addr));
        if (!exp.flush_done && rsp.last != exp.last)
            report_value("rsp.last", int'(exp.last), int'(rsp.last));
        if (exp.evict_valid && rsp.evict_addr != exp.evict_addr)
            report_value("rsp.evict_addr", int'(exp.evict_addr), int'(rsp.evict_addr));
        @(negedge clk);
    endtask

    task automatic check_all_rsp();
        int latency;
        while (exp_q.size() > 0)
            expect_rsp(exp_q.pop_front(), latency);
    endtask

    // queues the expected responses of one request in the order the DUT gives them.
    function automatic void predict_req(input llc_types_pkg::llc_req_t r);
        llc_types_pkg::llc_rsp_t   f;
        llc_types_pkg::line_addr_t a;
        if (r.cmd == llc_consts_pkg::CMD_FLUSH) begin
            invalidate_all();
            f            = '0;
            f.flush_done = 1'b1;
            exp_q.push_back(f);
        end else if (r.cmd == llc_consts_pkg::CMD_DMA_READ) begin
            a = r.addr;
            for (int i = 0; i <= int'(r.len_m1); i++) begin
                exp_q.push_back(lookup_line(a, i == int'(r.len_m1)));
                a = a + 1'b1;
            end
        end else begin
            exp_q.push_back(lookup_line(r.addr, 1'b1));
        end
    endfunction

    // few tags over few sets, so that hits and evictions both show up.
    function automatic llc_types_pkg::line_addr_t narrow_addr();
        llc_types_pkg::line_breakdown_llc_t b;
        b.tag = llc_types_pkg::llc_tag_t'($urandom_range(0, 7));
        b.set = llc_types_pkg::llc_set_t'($urandom_range(0, 3));
        return b;
    endfunction

    function automatic llc_types_pkg::llc_req_t random_req();
        llc_types_pkg::llc_req_t r;
        int unsigned             pick;
        pick     = $urandom_range(0, 9);
        r.cmd    = pick < 5 ? llc_consts_pkg::CMD_READ
                 : (pick < 9 ? llc_consts_pkg::CMD_DMA_READ : llc_consts_pkg::CMD_FLUSH);
        r.addr   = narrow_addr();
        r.len_m1 = llc_types_pkg::burst_len_t'($urandom_range(0, 15));
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------

    initial begin
        llc_types_pkg::llc_req_t            r;
        llc_types_pkg::llc_req_t            second;
        llc_types_pkg::line_breakdown_llc_t line;
        llc_types_pkg::line_breakdown_llc_t victim;
        llc_types_pkg::llc_set_t            first_set;
        int                                 latency;
        int                                 n;
        clk         = 1'b0;
        rst         = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        cycle_cnt   = 0;
        sent_cycle  = 0;
        errors      = 0;
        test_errors = 0;
        rsp_count   = 0;
        last_rsp    = '0;
        void'($urandom(SEED));
        invalidate_all();

        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b1;
        if (!busy)
            report_value("busy", 1, 0);
        if (ready)
            report_value("ready", 0, 1);
        if (rsp_valid)
            report_value("rsp_valid", 0, 1);
        n = 0;
        while (busy && n < 18) begin
            @(negedge clk);
            n++;
        end
        if (busy)
            report_fault("busy still high 18 cycles after reset");
        r      = '0;
        r.cmd  = llc_consts_pkg::CMD_READ;
        r.addr = llc_types_pkg::line_addr_t'($urandom());
        line   = r.addr;
        first_set = line.set;
        wait_idle();
        send_req(r);
        predict_req(r);
        check_all_rsp();
        if (last_rsp.hit)
            report_value("rsp.hit", 0, 1);
        if (last_rsp.evict_valid)
            report_value("rsp.evict_valid", 0, 1);
        report_test(1, "reset sweep");

        for (int i = 0; i < N_READS; i++) begin
            r      = '0;
            r.cmd  = llc_consts_pkg::CMD_READ;
            r.addr = narrow_addr();
            wait_idle();
            send_req(r);
            predict_req(r);
            expect_rsp(exp_q.pop_front(), latency);
            if (latency != 3)
                report_value("rsp latency", 3, latency);
        end
        report_test(2, "single reads");

        // sets above 3 are untouched by the reads before.
        do
            line.set = llc_types_pkg::llc_set_t'($urandom_range(4, 15));
        while (line.set == first_set);
        for (int i = 0; i < 8; i++) begin
            line.tag = llc_types_pkg::llc_tag_t'(8'ha0 + i);
            r        = '0;
            r.cmd    = llc_consts_pkg::CMD_READ;
            r.addr   = line;
            wait_idle();
            send_req(r);
            predict_req(r);
            check_all_rsp();
            if (i >= 4) begin
                victim.tag = llc_types_pkg::llc_tag_t'(8'ha0 + i - 4);
                victim.set = line.set;
                if (!last_rsp.evict_valid)
                    report_value("rsp.evict_valid", 1, 0);
                if (last_rsp.evict_addr != llc_types_pkg::line_addr_t'(victim))
                    report_value("rsp.evict_addr", int'(victim), int'(last_rsp.evict_addr));
            end
        end
        report_test(3, "round-robin eviction");

        for (int i = 0; i < N_DMA; i++) begin
            r     = random_req();
            r.cmd = llc_consts_pkg::CMD_DMA_READ;
            // the first burst runs past the top of the line address space.
            if (i == 0) begin
                r.addr   = 12'hffa;
                r.len_m1 = 4'd9;
            end
            wait_idle();
            send_req(r);
            predict_req(r);
            check_all_rsp();
        end
        report_test(4, "dma read");

        r     = '0;
        r.cmd = llc_consts_pkg::CMD_FLUSH;
        wait_idle();
        send_req(r);
        predict_req(r);
        check_all_rsp();
        for (int s = 0; s < llc_consts_pkg::LLC_SETS; s++) begin
            line.set = llc_types_pkg::llc_set_t'(s);
            line.tag = llc_types_pkg::llc_tag_t'($urandom_range(0, 7));
            r        = '0;
            r.cmd    = llc_consts_pkg::CMD_READ;
            r.addr   = line;
            wait_idle();
            send_req(r);
            predict_req(r);
            check_all_rsp();
            if (last_rsp.hit)
                report_value("rsp.hit", 0, 1);
            if (last_rsp.evict_valid)
                report_value("rsp.evict_valid", 0, 1);
        end
        report_test(5, "flush");

        for (int i = 0; i < N_HELD; i++) begin
            r      = random_req();
            second = random_req();
            wait_idle();
            send_req(r);
            send_req(second);
            if (ready)
                report_value("ready", 0, 1);
            predict_req(r);
            predict_req(second);
            check_all_rsp();
        end
        wait_idle();
        report_test(6, "held request");

        $display("summary: 6 tests, %0d responses checked, %0d errors", rsp_count, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * 2 * PERIOD);
        $display("watchdog: run did not finish within %0d cycles", RUN_CYCLES * 2);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- llc_top.sv
`timescale 1ns/1ps
`default_nettype none

module llc_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  llc_types_pkg::llc_req_t req,
    output logic                    ready,
    output logic                    busy,
    output logic                    rsp_valid,
    output llc_types_pkg::llc_rsp_t rsp
);

    // controller to register block.
    logic rst_state;
    logic decode_en;
    logic lookup_en;
    logic update_en;
    logic clr_rst_stall;
    logic set_flush_stall;
    logic clr_flush_stall;
    logic set_req_stall;
    logic clr_req_stall;
    logic incr_sweep_set;
    logic clr_sweep_set;
    logic load_dma_addr;
    logic incr_dma_addr;
    logic set_dma_read_pending;
    logic clr_dma_read_pending;

    // register block to controller.
    logic                      rst_stall;
    logic                      flush_stall;
    logic                      req_stall;
    logic                      dma_read_pending;
    logic                      evict_valid;
    llc_types_pkg::llc_set_t   sweep_set;
    llc_types_pkg::line_addr_t dma_addr;
    llc_types_pkg::burst_len_t lines_left;
    llc_types_pkg::llc_req_t   cur_req;
    llc_types_pkg::line_addr_t evict_addr;

    // tag array side.
    logic                               tag_wr_en;
    logic                               tag_clr_set;
    logic                               tag_advance;
    logic                               hit_way_found;
    llc_types_pkg::llc_way_t            tag_wr_way;
    llc_types_pkg::llc_way_t            hit_way;
    llc_types_pkg::llc_way_t            way_next;
    llc_types_pkg::llc_tags_t           tags_buf;
    llc_types_pkg::llc_valids_t         valid_buf;
    llc_types_pkg::line_breakdown_llc_t cur_line;

    assign cur_line = dma_addr;

    llc_ctrl llc_ctrl_i (.*);

    llc_regs llc_regs_i (
        .*,
        .held_req ()
    );

    llc_tag_array llc_tag_array_i (
        .clk        (clk),
        .rst        (rst),
        .rd_set     (cur_line.set),
        .tag_lookup (cur_line.tag),
        .wr_en      (tag_wr_en),
        .wr_way     (tag_wr_way),
        .wr_tag     (cur_line.tag),
        .clr_set    (sweep_set),
        .clr_en     (tag_clr_set),
        .advance    (tag_advance),
        .tags_buf   (tags_buf),
        .valid_buf  (valid_buf),
        .way_next   (way_next),
        .hit        (hit_way_found),
        .hit_way    (hit_way)
    );

endmodule

`default_nettype wire

//--- llc_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module llc_tag_array (
    input  logic                       clk,
    input  logic                       rst,
    input  llc_types_pkg::llc_set_t    rd_set,
    input  llc_types_pkg::llc_tag_t    tag_lookup,
    input  logic                       wr_en,
    input  llc_types_pkg::llc_way_t    wr_way,
    input  llc_types_pkg::llc_tag_t    wr_tag,
    input  llc_types_pkg::llc_set_t    clr_set,
    input  logic                       clr_en,
    input  logic                       advance,
    output llc_types_pkg::llc_tags_t   tags_buf,
    output llc_types_pkg::llc_valids_t valid_buf,
    output llc_types_pkg::llc_way_t    way_next,
    output logic                       hit,
    output llc_types_pkg::llc_way_t    hit_way
);

    llc_types_pkg::llc_tags_t   tags   [llc_consts_pkg::LLC_SETS];
    llc_types_pkg::llc_valids_t valids [llc_consts_pkg::LLC_SETS];
    llc_types_pkg::llc_way_t    ptrs   [llc_consts_pkg::LLC_SETS];

    assign tags_buf  = tags[rd_set];
    assign valid_buf = valids[rd_set];
    assign way_next  = ptrs[rd_set];

    // without a hit, hit_way falls back to the victim pointer.
    always_comb begin
        hit     = 1'b0;
        hit_way = way_next;
        for (int w = 0; w < llc_consts_pkg::LLC_WAYS; w++) begin
            if (valid_buf[w] && tags_buf[w] == tag_lookup) begin
                hit     = 1'b1;
                hit_way = llc_types_pkg::llc_way_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clr_en) begin
            valids[clr_set] <= '0;
        end else if (wr_en) begin
            tags[rd_set][wr_way]   <= wr_tag;
            valids[rd_set][wr_way] <= 1'b1;
        end
    end

    // round-robin victim pointer per set, wrapping modulo the way count.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_consts_pkg::LLC_SETS; s++)
                ptrs[s] <= '0;
        end else if (clr_en) begin
            ptrs[clr_set] <= '0;
        end else if (advance) begin
            ptrs[rd_set] <= ptrs[rd_set] + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- llc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module llc_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  logic                      rst_stall,
    input  logic                      flush_stall,
    input  logic                      req_stall,
    input  logic                      dma_read_pending,
    input  llc_types_pkg::llc_set_t   sweep_set,
    input  llc_types_pkg::line_addr_t dma_addr,
    input  llc_types_pkg::burst_len_t lines_left,
    input  llc_types_pkg::llc_req_t   cur_req,
    input  llc_types_pkg::line_addr_t evict_addr,
    input  logic                      evict_valid,
    input  logic                      hit_way_found,
    input  llc_types_pkg::llc_way_t   hit_way,
    output logic                      rst_state,
    output logic                      decode_en,
    output logic                      lookup_en,
    output logic                      update_en,
    output logic                      clr_rst_stall,
    output logic                      set_flush_stall,
    output logic                      clr_flush_stall,
    output logic                      set_req_stall,
    output logic                      clr_req_stall,
    output logic                      incr_sweep_set,
    output logic                      clr_sweep_set,
    output logic                      load_dma_addr,
    output logic                      incr_dma_addr,
    output logic                      set_dma_read_pending,
    output logic                      clr_dma_read_pending,
    output logic                      tag_wr_en,
    output llc_types_pkg::llc_way_t   tag_wr_way,
    output logic                      tag_clr_set,
    output logic                      tag_advance,
    output logic                      rsp_valid,
    output llc_types_pkg::llc_rsp_t   rsp,
    output logic                      busy
);

    llc_types_pkg::llc_state_t state;
    llc_types_pkg::llc_state_t next_state;
    logic                      last_set;

    assign last_set  = (sweep_set == llc_types_pkg::llc_set_t'(llc_consts_pkg::LLC_SETS - 1));
    assign rst_state = (state == llc_types_pkg::RST_SWEEP);
    assign decode_en = (state == llc_types_pkg::DECODE);
    assign lookup_en = (state == llc_types_pkg::LOOKUP);
    assign update_en = (state == llc_types_pkg::UPDATE);
    assign busy      = (state != llc_types_pkg::IDLE) | req_stall | flush_stall | rst_stall;

    // anything strobed outside IDLE waits in the holding slot.
    assign set_req_stall = req_valid && (state != llc_types_pkg::IDLE);

    // on a miss hit_way is the victim pointer, so one write serves both cases.
    assign tag_wr_way = hit_way;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            state <= llc_types_pkg::RST_SWEEP;
        else
            state <= next_state;
    end

    always_comb begin
        next_state           = state;
        clr_rst_stall        = 1'b0;
        set_flush_stall      = 1'b0;
        clr_flush_stall      = 1'b0;
        clr_req_stall        = 1'b0;
        incr_sweep_set       = 1'b0;
        clr_sweep_set        = 1'b0;
        load_dma_addr        = 1'b0;
        incr_dma_addr        = 1'b0;
        set_dma_read_pending = 1'b0;
        clr_dma_read_pending = 1'b0;
        tag_wr_en            = 1'b0;
        tag_clr_set          = 1'b0;
        tag_advance          = 1'b0;
        rsp_valid            = 1'b0;
        rsp                  = '0;
        case (state)
            llc_types_pkg::RST_SWEEP: begin
                tag_clr_set    = 1'b1;
                incr_sweep_set = 1'b1;
                if (last_set) begin
                    clr_rst_stall = 1'b1;
                    next_state    = llc_types_pkg::IDLE;
                end
            end
            llc_types_pkg::IDLE: begin
                if (req_stall) begin
                    clr_req_stall = 1'b1;
                    next_state    = llc_types_pkg::DECODE;
                end else if (req_valid) begin
                    next_state = llc_types_pkg::DECODE;
                end
            end
            llc_types_pkg::DECODE: begin
                // within a burst the address register already holds the next line.
                if (dma_read_pending) begin
                    next_state = llc_types_pkg::LOOKUP;
                end else begin
                    case (cur_req.cmd)
                        llc_consts_pkg::CMD_READ: begin
                            load_dma_addr = 1'b1;
                            next_state    = llc_types_pkg::LOOKUP;
                        end
                        llc_consts_pkg::CMD_DMA_READ: begin
                            load_dma_addr        = 1'b1;
                            set_dma_read_pending = 1'b1;
                            next_state           = llc_types_pkg::LOOKUP;
                        end
                        llc_consts_pkg::CMD_FLUSH: begin
                            set_flush_stall = 1'b1;
                            clr_sweep_set   = 1'b1;
                            next_state      = llc_types_pkg::FLUSH_SWEEP;
                        end
                        default: next_state = llc_types_pkg::IDLE;
                    endcase
                end
            end
            llc_types_pkg::LOOKUP: begin
                next_state = llc_types_pkg::UPDATE;
            end
            llc_types_pkg::UPDATE: begin
                tag_wr_en        = 1'b1;
                tag_advance      = !hit_way_found;
                incr_dma_addr    = 1'b1;
                rsp_valid        = 1'b1;
                rsp.addr         = dma_addr;
                rsp.hit          = hit_way_found;
                rsp.evict_valid  = evict_valid && !hit_way_found;
                rsp.evict_addr   = evict_addr;
                rsp.last         = (lines_left == '0);
                if (lines_left == '0) begin
                    clr_dma_read_pending = 1'b1;
                    next_state           = llc_types_pkg::IDLE;
                end else begin
                    next_state = llc_types_pkg::DECODE;
                end
            end
            llc_types_pkg::FLUSH_SWEEP: begin
                if (flush_stall) begin
                    tag_clr_set     = 1'b1;
                    incr_sweep_set  = 1'b1;
                    clr_flush_stall = last_set;
                end else begin
                    rsp_valid      = 1'b1;
                    rsp.flush_done = 1'b1;
                    next_state     = llc_types_pkg::IDLE;
                end
            end
            default: next_state = llc_types_pkg::IDLE;
        endcase
    end

    // a line response follows its lookup, a flush response follows the sweep of the last set.
    a_rsp_state: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid |-> (state == llc_types_pkg::UPDATE && $past(state) == llc_types_pkg::LOOKUP)
                      || (state == llc_types_pkg::FLUSH_SWEEP && !flush_stall
                          && $past(flush_stall) && $past(last_set)));

endmodule

`default_nettype wire

//--- llc_regs.sv
`timescale 1ns/1ps
`default_nettype none

module llc_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rst_state,
    input  logic                       decode_en,
    input  logic                       lookup_en,
    input  logic                       update_en,
    input  logic                       clr_rst_stall,
    input  logic                       set_flush_stall,
    input  logic                       clr_flush_stall,
    input  logic                       set_req_stall,
    input  logic                       clr_req_stall,
    input  logic                       incr_sweep_set,
    input  logic                       clr_sweep_set,
    input  logic                       load_dma_addr,
    input  logic                       incr_dma_addr,
    input  logic                       set_dma_read_pending,
    input  logic                       clr_dma_read_pending,
    input  logic                       req_valid,
    input  llc_types_pkg::llc_req_t    req,
    input  llc_types_pkg::llc_way_t    way_next,
    input  llc_types_pkg::llc_tags_t   tags_buf,
    input  llc_types_pkg::llc_valids_t valid_buf,
    output logic                       rst_stall,
    output logic                       flush_stall,
    output logic                       req_stall,
    output logic                       dma_read_pending,
    output llc_types_pkg::llc_set_t    sweep_set,
    output llc_types_pkg::line_addr_t  dma_addr,
    output llc_types_pkg::burst_len_t  lines_left,
    output llc_types_pkg::llc_req_t    cur_req,
    output llc_types_pkg::llc_req_t    held_req,
    output llc_types_pkg::line_addr_t  evict_addr,
    output logic                       evict_valid,
    output logic                       ready
);

    llc_types_pkg::line_breakdown_llc_t cur_line;

    assign cur_line = dma_addr;
    assign ready    = ~(req_stall | rst_stall);

    // ------------------------------------------------------------------------
    // controller flags, clear wins over set.
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            rst_stall <= 1'b1;
        else if (clr_rst_stall)
            rst_stall <= 1'b0;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_stall      <= 1'b0;
            req_stall        <= 1'b0;
            dma_read_pending <= 1'b0;
        end else begin
            if (rst_state || clr_flush_stall)
                flush_stall <= 1'b0;
            else if (set_flush_stall)
                flush_stall <= 1'b1;

            if (rst_state || clr_req_stall)
                req_stall <= 1'b0;
            else if (set_req_stall)
                req_stall <= 1'b1;

            if (rst_state || clr_dma_read_pending)
                dma_read_pending <= 1'b0;
            else if (set_dma_read_pending)
                dma_read_pending <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // counters.
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            sweep_set <= '0;
        else if (clr_sweep_set)
            sweep_set <= '0;
        else if (incr_sweep_set)
            sweep_set <= sweep_set + 1'b1;
    end

    // a single read loads zero lines left, so its first update is its last.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            lines_left <= '0;
        else if (rst_state)
            lines_left <= '0;
        else if (load_dma_addr)
            lines_left <= set_dma_read_pending ? cur_req.len_m1 : '0;
        else if (update_en && lines_left != '0)
            lines_left <= lines_left - 1'b1;
    end

    // the line address wraps within its 12 bits during a burst.
    always_ff @(posedge clk) begin
        if (load_dma_addr)
            dma_addr <= cur_req.addr;
        else if (incr_dma_addr)
            dma_addr <= dma_addr + 1'b1;
    end

    // ------------------------------------------------------------------------
    // current and held request.
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (set_req_stall)
            held_req <= req;
        if (clr_req_stall)
            cur_req <= held_req;
        else if (req_valid && !set_req_stall)
            cur_req <= req;
    end

    // victim of the current line, taken while the set is presented.
    always_ff @(posedge clk) begin
        if (lookup_en)
            evict_addr <= {tags_buf[way_next], cur_line.set};
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            evict_valid <= 1'b0;
        else if (decode_en)
            evict_valid <= 1'b0;
        else if (lookup_en)
            evict_valid <= valid_buf[way_next];
    end

    // the controller never raises and drops one flag in the same cycle.
    a_flag_strobes: assert property (@(posedge clk) disable iff (!rst)
        !(set_flush_stall && clr_flush_stall) && !(set_req_stall && clr_req_stall)
        && !(set_dma_read_pending && clr_dma_read_pending));

    // the outside strobes only while the holding slot is free.
    a_req_ready: assert property (@(posedge clk) disable iff (!rst)
        req_valid |-> ready);

endmodule

`default_nettype wire

//--- llc_types_pkg.sv
`default_nettype none

package llc_types_pkg;

    typedef logic [llc_consts_pkg::LLC_SET_BITS-1:0]   llc_set_t;
    typedef logic [llc_consts_pkg::LLC_TAG_BITS-1:0]   llc_tag_t;
    typedef logic [llc_consts_pkg::LLC_WAY_BITS-1:0]   llc_way_t;
    typedef logic [llc_consts_pkg::LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [llc_consts_pkg::LEN_BITS-1:0]       burst_len_t;
    typedef logic [llc_consts_pkg::CMD_BITS-1:0]       llc_cmd_t;

    // all tags and valid bits of one set, way 0 in the low slot.
    typedef llc_tag_t [llc_consts_pkg::LLC_WAYS-1:0] llc_tags_t;
    typedef logic [llc_consts_pkg::LLC_WAYS-1:0]     llc_valids_t;

    typedef struct packed {
        llc_tag_t tag;
        llc_set_t set;
    } line_breakdown_llc_t;

    typedef struct packed {
        llc_cmd_t   cmd;
        line_addr_t addr;
        burst_len_t len_m1;
    } llc_req_t;

    typedef struct packed {
        line_addr_t addr;
        logic       hit;
        logic       evict_valid;
        line_addr_t evict_addr;
        logic       last;
        logic       flush_done;
    } llc_rsp_t;

    typedef enum logic [2:0] {
        RST_SWEEP,
        IDLE,
        DECODE,
        LOOKUP,
        UPDATE,
        FLUSH_SWEEP
    } llc_state_t;

endpackage

`default_nettype wire

//--- llc_consts_pkg.sv
`default_nettype none

package llc_consts_pkg;

    // cache geometry.
    localparam int LLC_WAYS       = 4;
    localparam int LLC_SETS       = 16;
    localparam int LLC_SET_BITS   = 4;
    localparam int LLC_TAG_BITS   = 8;
    localparam int LLC_WAY_BITS   = 2;
    localparam int LINE_ADDR_BITS = LLC_TAG_BITS + LLC_SET_BITS;
    localparam int LEN_BITS       = 4;

    // request command codes.
    localparam int CMD_BITS = 2;

    localparam logic [CMD_BITS-1:0] CMD_READ     = 2'd0;
    localparam logic [CMD_BITS-1:0] CMD_DMA_READ = 2'd1;
    localparam logic [CMD_BITS-1:0] CMD_FLUSH    = 2'd2;

endpackage

`default_nettype wire
